// ==== simd_lane_defs.svh ====
/*
 * Global widths and AXI4-Lite register map
 * of the lane-serial SIMD ALU
 */

`ifndef SIMD_LANE_DEFS_SVH
`define SIMD_LANE_DEFS_SVH

// Datapath and bus widths
`define SL_DATA_W 32
`define SL_ADDR_W 5

// Register byte offsets
`define SL_ADDR_OPA    5'h00
`define SL_ADDR_OPB    5'h04
`define SL_ADDR_CTRL   5'h08
`define SL_ADDR_RESULT 5'h0C
`define SL_ADDR_STATUS 5'h10

`endif

// ==== simd_lane_pkg.sv ====
/*
 * Shared types: data vectors, op and width enums,
 * sequencer states, command, AXI4-Lite and lane result structs
 */

`default_nettype none

`include "simd_lane_defs.svh"

package simd_lane_pkg;

  typedef logic [`SL_DATA_W-1:0] data_t;
  // One element, zero-extended to a full word
  typedef logic [`SL_DATA_W-1:0] elem_t;
  typedef logic [`SL_ADDR_W-1:0] addr_t;
  typedef logic [1:0]            idx_t;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_SADDU = 4'd2,
    OP_SADD  = 4'd3,
    OP_SSUBU = 4'd4,
    OP_MINU  = 4'd5,
    OP_MIN   = 4'd6,
    OP_MAXU  = 4'd7,
    OP_MAX   = 4'd8,
    OP_SLL   = 4'd9,
    OP_SRL   = 4'd10,
    OP_SRA   = 4'd11,
    OP_AND   = 4'd12,
    OP_OR    = 4'd13,
    OP_XOR   = 4'd14
  } alu_op_e;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } vew_e;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_e;

  // CTRL layout: vew in [5:4], op in [3:0]
  typedef struct packed {
    vew_e    vew;
    alu_op_e op;
  } alu_cmd_t;

  typedef struct packed {
    addr_t                   awaddr;
    logic                    awvalid;
    data_t                   wdata;
    logic [`SL_DATA_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    bready;
    addr_t                   araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    data_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
  } axil_rsp_t;

  typedef struct packed {
    elem_t elem;
    logic  sat;
  } lane_res_t;

endpackage

`default_nettype wire

// ==== axil_regs.sv ====
/*
 * AXI4-Lite register slave: write and read channels,
 * user operand registers, working copies of the command
 * and operands, result assembly and sticky saturation
 */

`timescale 1ns/1ns
`default_nettype none

`include "simd_lane_defs.svh"

module axil_regs (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  simd_lane_pkg::axil_req_t axil_req_i,
  output simd_lane_pkg::axil_rsp_t axil_rsp_o,
  input  logic                     accept_i,
  input  logic                     busy_i,
  input  simd_lane_pkg::idx_t      idx_i,
  input  simd_lane_pkg::lane_res_t lane_i,
  output logic                     ctrl_wr_o,
  output simd_lane_pkg::alu_cmd_t  cmd_wr_o,
  output simd_lane_pkg::alu_cmd_t  cmd_o,
  output simd_lane_pkg::data_t     opa_o,
  output simd_lane_pkg::data_t     opb_o
);

  simd_lane_pkg::data_t    opa_q, opb_q;
  simd_lane_pkg::data_t    opa_wk, opb_wk;
  simd_lane_pkg::data_t    res_q, rdata_q, rd_mux;
  simd_lane_pkg::alu_cmd_t cmd_q;
  logic                    sat_q;
  logic                    bvalid_q, rvalid_q;
  logic                    wr_go, rd_go;

  ////////////////////
  // Handshakes
  ////////////////////

  // One write or read in flight per channel
  assign wr_go = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign rd_go = axil_req_i.arvalid & ~rvalid_q;

  assign ctrl_wr_o = wr_go & (axil_req_i.awaddr == `SL_ADDR_CTRL);
  assign cmd_wr_o  = simd_lane_pkg::alu_cmd_t'(
                       axil_req_i.wdata[$bits(simd_lane_pkg::alu_cmd_t)-1:0]);

  always_comb begin
    axil_rsp_o.awready = wr_go;
    axil_rsp_o.wready  = wr_go;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = 2'b00;
    axil_rsp_o.arready = rd_go;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = 2'b00;
    axil_rsp_o.rvalid  = rvalid_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      if (wr_go) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_mux;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Read mux, unmapped offsets give zero
  always_comb begin
    case (axil_req_i.araddr)
      `SL_ADDR_OPA:    rd_mux = opa_q;
      `SL_ADDR_OPB:    rd_mux = opb_q;
      `SL_ADDR_CTRL:   rd_mux = simd_lane_pkg::data_t'(cmd_q);
      `SL_ADDR_RESULT: rd_mux = res_q;
      `SL_ADDR_STATUS: rd_mux = {{(`SL_DATA_W-2){1'b0}}, sat_q, busy_i};
      default:         rd_mux = '0;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  // User copies, free to change while a run is in progress
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      opa_q <= '0;
      opb_q <= '0;
    end else if (wr_go) begin
      case (axil_req_i.awaddr)
        `SL_ADDR_OPA: opa_q <= axil_req_i.wdata;
        `SL_ADDR_OPB: opb_q <= axil_req_i.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_q  <= '0;
      opa_wk <= '0;
      opb_wk <= '0;
      res_q  <= '0;
      sat_q  <= 1'b0;
    end else if (accept_i) begin
      cmd_q  <= cmd_wr_o;
      opa_wk <= opa_q;
      opb_wk <= opb_q;
      res_q  <= '0;
      sat_q  <= 1'b0;
    end else if (busy_i) begin
      // Drop the lane result into its slot
      case (cmd_q.vew)
        simd_lane_pkg::EW8:  res_q[{idx_i, 3'b000} +: 8]     <= lane_i.elem[7:0];
        simd_lane_pkg::EW16: res_q[{idx_i[0], 4'b0000} +: 16] <= lane_i.elem[15:0];
        default:             res_q <= lane_i.elem;
      endcase
      sat_q <= sat_q | lane_i.sat;
    end
  end

  assign cmd_o = cmd_q;
  assign opa_o = opa_wk;
  assign opb_o = opb_wk;

endmodule

`default_nettype wire

// ==== lane_seq_fsm.sv ====
/*
 * Idle/run sequencer: takes a start from a CTRL write
 * and ends the run on the last element
 */

`timescale 1ns/1ns
`default_nettype none

module lane_seq_fsm (
  input  logic clk_i,
  input  logic rst_i,
  input  logic ctrl_wr_i,
  input  logic last_i,
  output logic accept_o,
  output logic busy_o
);

  simd_lane_pkg::seq_state_e state_q, state_d;

  // Starts while running are dropped
  assign accept_o = ctrl_wr_i & (state_q == simd_lane_pkg::SEQ_IDLE);
  assign busy_o   = (state_q == simd_lane_pkg::SEQ_RUN);

  always_comb begin
    state_d = state_q;
    case (state_q)
      simd_lane_pkg::SEQ_IDLE: begin
        if (accept_o) begin
          state_d = simd_lane_pkg::SEQ_RUN;
        end
      end
      simd_lane_pkg::SEQ_RUN: begin
        if (last_i) begin
          state_d = simd_lane_pkg::SEQ_IDLE;
        end
      end
      default: state_d = simd_lane_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= simd_lane_pkg::SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== elem_counter.sv ====
/*
 * Element index counter, last index set by the element width
 */

`timescale 1ns/1ns
`default_nettype none

module elem_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 load_i,
  input  logic                 step_i,
  input  simd_lane_pkg::vew_e  vew_i,
  output simd_lane_pkg::idx_t  idx_o,
  output logic                 last_o
);

  simd_lane_pkg::idx_t idx_q, last_idx;
  simd_lane_pkg::vew_e vew_q;

  // Width captured with the start, like the working command
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      idx_q <= '0;
      vew_q <= simd_lane_pkg::EW8;
    end else if (load_i) begin
      idx_q <= '0;
      vew_q <= vew_i;
    end else if (step_i) begin
      idx_q <= idx_q + 2'd1;
    end
  end

  always_comb begin
    case (vew_q)
      simd_lane_pkg::EW8:  last_idx = 2'd3;
      simd_lane_pkg::EW16: last_idx = 2'd1;
      default:             last_idx = 2'd0;
    endcase
  end

  assign idx_o  = idx_q;
  assign last_o = (idx_q == last_idx);

endmodule

`default_nettype wire

// ==== lane_alu.sv ====
/*
 * Single-element ALU stage: element select and extension,
 * arithmetic, saturation, min/max, shifts and logic ops
 */

`timescale 1ns/1ns
`default_nettype none

`include "simd_lane_defs.svh"

module lane_alu (
  input  simd_lane_pkg::data_t     opa_i,
  input  simd_lane_pkg::data_t     opb_i,
  input  simd_lane_pkg::alu_cmd_t  cmd_i,
  input  simd_lane_pkg::idx_t      idx_i,
  output simd_lane_pkg::lane_res_t lane_o
);

  simd_lane_pkg::elem_t mask, top, a_el, b_el, b_sx, res;
  logic [4:0]           off, shmask, shamt;
  logic                 is_signed, sa, sb, less, sat;
  logic signed [`SL_DATA_W:0] a_x, b_x, sum, diff, smax, smin;

  ////////////////////
  // Element select
  ////////////////////

  always_comb begin
    case (cmd_i.vew)
      simd_lane_pkg::EW8: begin
        mask   = 32'h0000_00ff;
        off    = {idx_i, 3'b000};
        shmask = 5'h07;
      end
      simd_lane_pkg::EW16: begin
        mask   = 32'h0000_ffff;
        off    = {idx_i[0], 4'h0};
        shmask = 5'h0f;
      end
      default: begin
        mask   = '1;
        off    = '0;
        shmask = 5'h1f;
      end
    endcase
  end

  assign top  = mask & ~(mask >> 1);
  assign a_el = (opa_i >> off) & mask;
  assign b_el = (opb_i >> off) & mask;
  assign sa   = |(a_el & top);
  assign sb   = |(b_el & top);

  assign is_signed = cmd_i.op inside {simd_lane_pkg::OP_SADD, simd_lane_pkg::OP_MIN,
                                      simd_lane_pkg::OP_MAX};

  // One extra bit keeps carries and signs
  assign a_x  = {is_signed & sa, a_el | ({`SL_DATA_W{is_signed & sa}} & ~mask)};
  assign b_x  = {is_signed & sb, b_el | ({`SL_DATA_W{is_signed & sb}} & ~mask)};
  assign b_sx = b_el | ({`SL_DATA_W{sb}} & ~mask);

  assign sum   = a_x + b_x;
  assign diff  = b_x - a_x;
  assign less  = b_x < a_x;
  assign smax  = {1'b0, mask >> 1};
  assign smin  = ~smax;
  assign shamt = a_el[4:0] & shmask;

  ////////////////////
  // Operation
  ////////////////////

  always_comb begin
    res = '0;
    sat = 1'b0;
    case (cmd_i.op)
      simd_lane_pkg::OP_ADD: res = sum[`SL_DATA_W-1:0];
      simd_lane_pkg::OP_SUB: res = diff[`SL_DATA_W-1:0];
      simd_lane_pkg::OP_SADDU: begin
        sat = |(sum & ~{1'b0, mask});
        res = sat ? mask : sum[`SL_DATA_W-1:0];
      end
      simd_lane_pkg::OP_SADD: begin
        if (sum > smax) begin
          sat = 1'b1;
          res = smax[`SL_DATA_W-1:0];
        end else if (sum < smin) begin
          sat = 1'b1;
          res = smin[`SL_DATA_W-1:0];
        end else begin
          res = sum[`SL_DATA_W-1:0];
        end
      end
      simd_lane_pkg::OP_SSUBU: begin
        // Borrow clamps to zero
        sat = diff[`SL_DATA_W];
        res = sat ? '0 : diff[`SL_DATA_W-1:0];
      end
      simd_lane_pkg::OP_MINU, simd_lane_pkg::OP_MIN: res = less ? b_el : a_el;
      simd_lane_pkg::OP_MAXU, simd_lane_pkg::OP_MAX: res = less ? a_el : b_el;
      simd_lane_pkg::OP_SLL: res = b_el << shamt;
      simd_lane_pkg::OP_SRL: res = b_el >> shamt;
      simd_lane_pkg::OP_SRA: res = $signed(b_sx) >>> shamt;
      simd_lane_pkg::OP_AND: res = a_el & b_el;
      simd_lane_pkg::OP_OR:  res = a_el | b_el;
      simd_lane_pkg::OP_XOR: res = a_el ^ b_el;
      default: ;
    endcase
    lane_o.elem = res & mask;
    lane_o.sat  = sat;
  end

endmodule

`default_nettype wire

// ==== simd_alu_top.sv ====
/*
 * Lane-serial SIMD ALU behind an AXI4-Lite slave
 */

`timescale 1ns/1ns
`default_nettype none

module simd_alu_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  simd_lane_pkg::axil_req_t axil_req_i,
  output simd_lane_pkg::axil_rsp_t axil_rsp_o
);

  logic                     ctrl_wr, accept, busy, last;
  simd_lane_pkg::alu_cmd_t  cmd_wr, cmd;
  simd_lane_pkg::data_t     opa, opb;
  simd_lane_pkg::idx_t      idx;
  simd_lane_pkg::lane_res_t lane;

  axil_regs i_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .accept_i   (accept),
    .busy_i     (busy),
    .idx_i      (idx),
    .lane_i     (lane),
    .ctrl_wr_o  (ctrl_wr),
    .cmd_wr_o   (cmd_wr),
    .cmd_o      (cmd),
    .opa_o      (opa),
    .opb_o      (opb)
  );

  lane_seq_fsm i_fsm (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ctrl_wr_i (ctrl_wr),
    .last_i    (last),
    .accept_o  (accept),
    .busy_o    (busy)
  );

  elem_counter i_cnt (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .load_i (accept),
    .step_i (busy),
    .vew_i  (cmd_wr.vew),
    .idx_o  (idx),
    .last_o (last)
  );

  lane_alu i_alu (
    .opa_i  (opa),
    .opb_i  (opb),
    .cmd_i  (cmd),
    .idx_i  (idx),
    .lane_o (lane)
  );

endmodule

`default_nettype wire

// ==== simd_alu_sva.sv ====
/*
 * Bus handshake and run length assertions,
 * bound to the SIMD ALU top level
 */

`timescale 1ns/1ns
`default_nettype none

module simd_alu_sva (
  input logic                     clk_i,
  input logic                     rst_i,
  input simd_lane_pkg::axil_req_t axil_req_i,
  input simd_lane_pkg::axil_rsp_t axil_rsp_i,
  input logic                     busy_i
);

  logic [3:0] busy_len;

  // Cycles spent busy in the current run
  always_ff @(posedge clk_i) begin
    if (rst_i || !busy_i) begin
      busy_len <= '0;
    end else begin
      busy_len <= busy_len + 4'd1;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
    else $error("rvalid or rdata changed before rready");

  a_busy_len: assert property (@(posedge clk_i) disable iff (rst_i) busy_len <= 4'd4)
    else $error("busy held longer than four cycles");

  a_aw_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    axil_rsp_i.awready |-> axil_req_i.awvalid && axil_req_i.wvalid)
    else $error("awready without awvalid and wvalid");

endmodule

bind simd_alu_top simd_alu_sva i_sva (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o),
  .busy_i     (busy)
);

`default_nettype wire

// ==== tb_simd_alu.sv ====
/*
 * Testbench for the lane-serial SIMD ALU: clock and reset,
 * AXI4-Lite register access, random and directed operations,
 * reference model and result checks
 */

`timescale 1ns/1ns
`default_nettype none

`include "simd_lane_defs.svh"

module tb_simd_alu;

  localparam int TIMEOUT = 200;

  logic                     clk;
  logic                     rst;
  simd_lane_pkg::axil_req_t req;
  simd_lane_pkg::axil_rsp_t rsp;
  integer                   seed;

  simd_alu_top uut (
    .clk_i      (clk),
    .rst_i      (rst),
    .axil_req_i (req),
    .axil_rsp_o (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input simd_lane_pkg::data_t exp,
                            input simd_lane_pkg::data_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_sat(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp,
                            input logic [1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, act));
    end
  endtask

  ////////////////////
  // Bus access
  ////////////////////

  task automatic write_reg(input simd_lane_pkg::addr_t addr,
                           input simd_lane_pkg::data_t data);
    int t;
    @(negedge clk);
    req.awaddr  = addr;
    req.wdata   = data;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    t = 0;
    #1;
    while (!rsp.awready) begin
      t++;
      if (t > TIMEOUT) begin
        fail_run("write was never accepted by the slave");
      end
      @(negedge clk);
      #1;
    end
    if (!rsp.wready) begin
      fail_run("wready was low in the write handshake cycle");
    end
    @(negedge clk);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    t = 0;
    while (!rsp.bvalid) begin
      t++;
      if (t > TIMEOUT) begin
        fail_run("write response never arrived");
      end
      @(negedge clk);
    end
    check_resp("bresp", 2'b00, rsp.bresp);
  endtask

  task automatic read_reg(input simd_lane_pkg::addr_t addr, input int stall,
                          output simd_lane_pkg::data_t data);
    int t;
    @(negedge clk);
    req.araddr  = addr;
    req.arvalid = 1'b1;
    req.rready  = 1'b0;
    t = 0;
    #1;
    while (!rsp.arready) begin
      t++;
      if (t > TIMEOUT) begin
        fail_run("read address was never accepted by the slave");
      end
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req.arvalid = 1'b0;
    t = 0;
    while (!rsp.rvalid) begin
      t++;
      if (t > TIMEOUT) begin
        fail_run("read data never arrived");
      end
      @(negedge clk);
    end
    data = rsp.rdata;
    check_resp("rresp", 2'b00, rsp.rresp);
    // Slave must hold the data while rready is low
    repeat (stall) begin
      @(negedge clk);
      if (!rsp.rvalid) begin
        fail_run("read data was dropped while rready was low");
      end
      check_data("rdata", data, rsp.rdata);
    end
    req.rready = 1'b1;
  endtask

  task automatic wait_idle(output logic sat);
    simd_lane_pkg::data_t st;
    int                   t;
    t = 0;
    read_reg(`SL_ADDR_STATUS, 0, st);
    while (st[0]) begin
      t++;
      if (t > TIMEOUT) begin
        fail_run("operation never left the busy state");
      end
      read_reg(`SL_ADDR_STATUS, 0, st);
    end
    sat = st[1];
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  task automatic model_op(input simd_lane_pkg::alu_op_e op, input simd_lane_pkg::vew_e vew,
                          input simd_lane_pkg::data_t a, input simd_lane_pkg::data_t b,
                          output simd_lane_pkg::data_t res, output logic sat);
    int     sew, sh, i;
    longint umax, smax, ua, ub, sa, sb, r, acc;
    sew  = (vew == simd_lane_pkg::EW8) ? 8 : (vew == simd_lane_pkg::EW16) ? 16 : 32;
    umax = (64'sd1 <<< sew) - 64'sd1;
    smax = umax >> 1;
    acc  = 64'sd0;
    sat  = 1'b0;
    for (i = 0; i < `SL_DATA_W / sew; i++) begin
      ua = (longint'(a) >> (i * sew)) & umax;
      ub = (longint'(b) >> (i * sew)) & umax;
      sa = (ua > smax) ? ua - umax - 64'sd1 : ua;
      sb = (ub > smax) ? ub - umax - 64'sd1 : ub;
      sh = int'(ua & longint'(sew - 1));
      case (op)
        simd_lane_pkg::OP_ADD:   r = ua + ub;
        simd_lane_pkg::OP_SUB:   r = ub - ua;
        simd_lane_pkg::OP_SADDU: r = ua + ub;
        simd_lane_pkg::OP_SADD:  r = sa + sb;
        simd_lane_pkg::OP_SSUBU: r = ub - ua;
        simd_lane_pkg::OP_MINU:  r = (ua < ub) ? ua : ub;
        simd_lane_pkg::OP_MIN:   r = (sa < sb) ? sa : sb;
        simd_lane_pkg::OP_MAXU:  r = (ua > ub) ? ua : ub;
        simd_lane_pkg::OP_MAX:   r = (sa > sb) ? sa : sb;
        simd_lane_pkg::OP_SLL:   r = ub << sh;
        simd_lane_pkg::OP_SRL:   r = ub >> sh;
        simd_lane_pkg::OP_SRA:   r = sb >>> sh;
        simd_lane_pkg::OP_AND:   r = ua & ub;
        simd_lane_pkg::OP_OR:    r = ua | ub;
        simd_lane_pkg::OP_XOR:   r = ua ^ ub;
        default:                 r = 64'sd0;
      endcase
      // Clamp to the element limits
      if (op == simd_lane_pkg::OP_SADDU && r > umax) begin
        r   = umax;
        sat = 1'b1;
      end
      if (op == simd_lane_pkg::OP_SADD && (r > smax || r < -smax - 64'sd1)) begin
        r   = (r > smax) ? smax : -smax - 64'sd1;
        sat = 1'b1;
      end
      if (op == simd_lane_pkg::OP_SSUBU && r < 64'sd0) begin
        r   = 64'sd0;
        sat = 1'b1;
      end
      acc = acc | ((r & umax) << (i * sew));
    end
    res = acc[`SL_DATA_W-1:0];
  endtask

  task automatic run_op(input simd_lane_pkg::alu_op_e op, input simd_lane_pkg::vew_e vew,
                        input simd_lane_pkg::data_t a, input simd_lane_pkg::data_t b,
                        output logic sat);
    simd_lane_pkg::alu_cmd_t cmd;
    simd_lane_pkg::data_t    exp_res, got_res;
    logic                    exp_sat;
    cmd.op  = op;
    cmd.vew = vew;
    write_reg(`SL_ADDR_OPA, a);
    write_reg(`SL_ADDR_OPB, b);
    write_reg(`SL_ADDR_CTRL, simd_lane_pkg::data_t'(cmd));
    wait_idle(sat);
    read_reg(`SL_ADDR_RESULT, $random(seed) & 3, got_res);
    model_op(op, vew, a, b, exp_res, exp_sat);
    check_data("RESULT", exp_res, got_res);
    check_sat("STATUS.sat", exp_sat, sat);
  endtask

  // Saturating op sets the flag, the next clean op clears it
  task automatic sticky_then_clear(input simd_lane_pkg::alu_op_e op,
                                   input simd_lane_pkg::vew_e vew,
                                   input simd_lane_pkg::data_t a,
                                   input simd_lane_pkg::data_t b);
    logic sat;
    run_op(op, vew, a, b, sat);
    check_sat("STATUS.sat", 1'b1, sat);
    run_op(simd_lane_pkg::OP_XOR, vew, a, b, sat);
    check_sat("STATUS.sat", 1'b0, sat);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    simd_lane_pkg::data_t    a, b, d, exp_res;
    simd_lane_pkg::alu_op_e  op;
    simd_lane_pkg::vew_e     vew;
    simd_lane_pkg::alu_cmd_t cmd;
    logic                    sat, exp_sat;
    int                      i;
    seed       = 32'heaae_d4f7;
    req        = '0;
    req.wstrb  = '1;
    req.bready = 1'b1;
    rst        = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (i = 0; i < 200; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      d   = $random(seed);
      op  = simd_lane_pkg::alu_op_e'(4'(d % 15));
      vew = simd_lane_pkg::vew_e'(2'((d >> 8) % 3));
      run_op(op, vew, a, b, sat);
    end

    for (i = 0; i < 3; i++) begin
      vew = simd_lane_pkg::vew_e'(2'(i));
      sticky_then_clear(simd_lane_pkg::OP_SADDU, vew, 32'hffff_ffff, 32'h0101_0101);
      sticky_then_clear(simd_lane_pkg::OP_SADD, vew, 32'h7fff_7fff, 32'h0101_0101);
      sticky_then_clear(simd_lane_pkg::OP_SADD, vew, 32'h8080_8080, 32'h8080_8080);
      sticky_then_clear(simd_lane_pkg::OP_SSUBU, vew, 32'h0101_0101, 32'h0000_0000);
    end

    // Shift amounts with junk above the used bits
    for (i = 0; i < 30; i++) begin
      d   = $random(seed);
      a   = $random(seed) | 32'he0e0_e0e0;
      b   = $random(seed);
      op  = simd_lane_pkg::alu_op_e'(4'(9 + d % 3));
      vew = simd_lane_pkg::vew_e'(2'((d >> 4) % 3));
      run_op(op, vew, a, b, sat);
    end

    // Operand write and a second start land during an EW8 run
    a       = $random(seed);
    b       = $random(seed);
    cmd.op  = simd_lane_pkg::OP_ADD;
    cmd.vew = simd_lane_pkg::EW8;
    write_reg(`SL_ADDR_OPA, a);
    write_reg(`SL_ADDR_OPB, b);
    write_reg(`SL_ADDR_CTRL, simd_lane_pkg::data_t'(cmd));
    write_reg(`SL_ADDR_OPA, ~a);
    cmd.op  = simd_lane_pkg::OP_XOR;
    cmd.vew = simd_lane_pkg::EW32;
    write_reg(`SL_ADDR_CTRL, simd_lane_pkg::data_t'(cmd));
    write_reg(`SL_ADDR_OPB, ~b);
    wait_idle(sat);
    read_reg(`SL_ADDR_RESULT, 0, d);
    model_op(simd_lane_pkg::OP_ADD, simd_lane_pkg::EW8, a, b, exp_res, exp_sat);
    check_data("RESULT", exp_res, d);
    check_sat("STATUS.sat", exp_sat, sat);
    read_reg(`SL_ADDR_CTRL, 0, d);
    check_data("CTRL", 32'h0000_0000, d);
    read_reg(`SL_ADDR_OPA, 0, d);
    check_data("OPA", ~a, d);

    for (i = 0; i < 20; i++) begin
      a = $random(seed);
      write_reg(`SL_ADDR_OPB, a);
      read_reg(`SL_ADDR_OPB, 1 + ($random(seed) & 7), d);
      check_data("OPB", a, d);
    end
    for (i = 0; i < 6; i++) begin
      read_reg(simd_lane_pkg::addr_t'(20 + 2 * i), 1 + ($random(seed) & 3), d);
      check_data("unmapped rdata", 32'h0000_0000, d);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
simd_lane_pkg.sv
axil_regs.sv
lane_seq_fsm.sv
elem_counter.sv
lane_alu.sv
simd_alu_top.sv
simd_alu_sva.sv
tb_simd_alu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_simd_alu \
  --Mdir obj_dir -o tb_simd_alu
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_simd_alu
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi
exit 0
